// File: design/operand_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand decoder types.
// Instruction bytes, the format record that locates each operand
// field, and the decoded field result.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package operand_pkg;

    // Bytes examined per instruction: opcode, escape or ModRM, ModRM.
    localparam int FETCH_BYTES = 3;

    // Byte 0 is the first opcode byte and sits in the low bits.
    typedef logic [FETCH_BYTES-1:0][7:0] instr_bytes_t;

    // Source of the width bit.
    typedef enum logic [1:0] {
        W_NONE    = 2'd0,
        W_B0_BIT0 = 2'd1, // Ordinary w bit of one-byte opcodes.
        W_B0_BIT3 = 2'd2, // MOV immediate to register, short form.
        W_B1_BIT0 = 2'd3  // MOVZX and MOVSX after the 0F escape.
    } w_src_e;

    // Source of the general-purpose register number.
    typedef enum logic [1:0] {
        REG_NONE   = 2'd0,
        REG_B0_LOW = 2'd1, // Register encoded in the opcode itself.
        REG_B1_MID = 2'd2, // Reg field of a ModRM in byte 1.
        REG_B2_MID = 2'd3  // Reg field of a ModRM in byte 2.
    } reg_src_e;

    // Byte that holds the ModRM mod and rm fields.
    typedef enum logic [1:0] {
        MODRM_NONE = 2'd0,
        MODRM_B1   = 2'd1,
        MODRM_B2   = 2'd2
    } modrm_src_e;

    // Where every operand field of one opcode lives.
    typedef struct packed {
        logic       s_en;      // s is byte 0 bit 1.
        w_src_e     w_src;
        reg_src_e   reg_src;
        modrm_src_e modrm_src;
        logic       sreg3_en;  // sreg3 is byte 1 bits 5:3.
        logic       sreg2_en;  // sreg2 is byte 0 bits 4:3.
    } operand_format_t;

    // Payload of the first pipeline slice.
    typedef struct packed {
        instr_bytes_t    bytes;
        operand_format_t format;
    } format_req_t;

    // Decoded operand fields, zero wherever the opcode has no such field.
    typedef struct packed {
        logic       s;
        logic       w;
        logic [2:0] gpr;
        logic [2:0] sreg3;
        logic [1:0] sreg2;
        logic [1:0] mod;
        logic [2:0] rm;
    } operand_fields_t;

endpackage

// File: design/operand_format_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand format decoder.
// Classifies the opcode, one byte or 0F plus one, into the
// locations of its operand fields.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module operand_format_decoder (
    input  operand_pkg::instr_bytes_t    bytes,
    output operand_pkg::operand_format_t format
);

    localparam logic [7:0] TWO_BYTE_ESCAPE = 8'h0F;

    operand_pkg::operand_format_t one_byte_format;
    operand_pkg::operand_format_t two_byte_format;

    // One-byte opcodes, classified from byte 0.
    always_comb begin
        one_byte_format = '0;
        unique casez (bytes[0])
            8'b00???0??: begin // ALU r/m: ADD, OR, ADC, SBB, AND, SUB, XOR, CMP.
                one_byte_format.w_src     = operand_pkg::W_B0_BIT0;
                one_byte_format.modrm_src = operand_pkg::MODRM_B1;
            end
            8'h80, 8'h81, 8'h83: begin // Immediate group, operation in ModRM reg.
                one_byte_format.s_en      = 1'b1;
                one_byte_format.w_src     = operand_pkg::W_B0_BIT0;
                one_byte_format.modrm_src = operand_pkg::MODRM_B1;
            end
            8'b1000_10??: begin // MOV r/m in both directions.
                one_byte_format.w_src     = operand_pkg::W_B0_BIT0;
                one_byte_format.reg_src   = operand_pkg::REG_B1_MID;
                one_byte_format.modrm_src = operand_pkg::MODRM_B1;
            end
            8'h8C, 8'h8E: begin // MOV to and from a segment register.
                one_byte_format.sreg3_en  = 1'b1;
                one_byte_format.modrm_src = operand_pkg::MODRM_B1;
            end
            8'b010?_????, 8'b1001_0???: begin // INC, DEC, PUSH, POP, XCHG with acc.
                one_byte_format.reg_src = operand_pkg::REG_B0_LOW;
            end
            8'b1011_????: begin // MOV immediate to register.
                one_byte_format.w_src   = operand_pkg::W_B0_BIT3;
                one_byte_format.reg_src = operand_pkg::REG_B0_LOW;
            end
            8'h06, 8'h07, 8'h0E, 8'h16, 8'h17, 8'h1E, 8'h1F: begin
                one_byte_format.sreg2_en = 1'b1; // PUSH and POP of ES, CS, SS, DS.
            end
            default: begin
                one_byte_format = '0;
            end
        endcase
    end

    // Two-byte opcodes, classified from byte 1 after the escape.
    always_comb begin
        two_byte_format = '0;
        unique casez (bytes[1])
            8'hB6, 8'hB7, 8'hBE, 8'hBF: begin // MOVZX and MOVSX.
                two_byte_format.w_src     = operand_pkg::W_B1_BIT0;
                two_byte_format.reg_src   = operand_pkg::REG_B2_MID;
                two_byte_format.modrm_src = operand_pkg::MODRM_B2;
            end
            8'hBC, 8'hBD: begin // BSF and BSR.
                two_byte_format.reg_src   = operand_pkg::REG_B2_MID;
                two_byte_format.modrm_src = operand_pkg::MODRM_B2;
            end
            8'b1001_????: begin // SETcc, one per condition code.
                two_byte_format.modrm_src = operand_pkg::MODRM_B2;
            end
            8'hA0, 8'hA1, 8'hA8, 8'hA9: begin
                two_byte_format.sreg3_en = 1'b1; // FS or GS sits in byte 1 bits 5:3.
            end
            default: begin
                two_byte_format = '0;
            end
        endcase
    end

    assign format = (bytes[0] == TWO_BYTE_ESCAPE) ? two_byte_format : one_byte_format;

    // A two-bit segment field only comes with opcodes that carry no ModRM.
    always_comb begin
        assert final (!(format.sreg2_en && format.modrm_src != operand_pkg::MODRM_NONE))
            else $error("format decoder selects sreg2 and mod/rm for opcode %h", bytes[0]);
    end

endmodule

// File: design/operand_field_select.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand field selector.
// Pulls each operand field out of the instruction bytes at the
// place that the format record names.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module operand_field_select (
    input  operand_pkg::instr_bytes_t    bytes,
    input  operand_pkg::operand_format_t format,
    output operand_pkg::operand_fields_t fields
);

    always_comb begin
        fields = '0; // Fields without a location stay zero.

        if (format.s_en) begin
            fields.s = bytes[0][1];
        end

        unique case (format.w_src)
            operand_pkg::W_B0_BIT0: fields.w = bytes[0][0];
            operand_pkg::W_B0_BIT3: fields.w = bytes[0][3];
            operand_pkg::W_B1_BIT0: fields.w = bytes[1][0];
            default:                fields.w = 1'b0;
        endcase

        unique case (format.reg_src)
            operand_pkg::REG_B0_LOW: fields.gpr = bytes[0][2:0];
            operand_pkg::REG_B1_MID: fields.gpr = bytes[1][5:3];
            operand_pkg::REG_B2_MID: fields.gpr = bytes[2][5:3];
            default:                 fields.gpr = 3'd0;
        endcase

        if (format.sreg3_en) begin
            fields.sreg3 = bytes[1][5:3];
        end

        if (format.sreg2_en) begin
            fields.sreg2 = bytes[0][4:3];
        end

        unique case (format.modrm_src)
            operand_pkg::MODRM_B1: begin
                fields.mod = bytes[1][7:6];
                fields.rm  = bytes[1][2:0];
            end
            operand_pkg::MODRM_B2: begin
                fields.mod = bytes[2][7:6];
                fields.rm  = bytes[2][2:0];
            end
            default: begin
                fields.mod = 2'd0;
                fields.rm  = 3'd0;
            end
        endcase
    end

endmodule

// File: design/decode_pipe_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Valid/ready register slice.
// Full throughput, one cycle of latency, any payload type.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module decode_pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // Accept when empty or when the held item leaves this cycle.
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

    // A stalled item must not change under the consumer.
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> $stable(out_data))
        else $error("pipe stage changed its output while stalled");

endmodule

// File: design/operand_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// x86 operand field decoder.
// Format lookup, a register slice, field extraction, and a second
// slice on the result.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module operand_decoder (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  operand_pkg::instr_bytes_t    in_bytes,
    output logic                         out_valid,
    input  logic                         out_ready,
    output operand_pkg::operand_fields_t out_fields
);

    operand_pkg::operand_format_t format;
    operand_pkg::format_req_t     req_in;
    operand_pkg::format_req_t     req_q;
    logic                         req_valid;
    logic                         req_ready;
    operand_pkg::operand_fields_t fields;

    operand_format_decoder operand_format_decoder_inst (
        .bytes  (in_bytes),
        .format (format)
    );

    assign req_in.bytes  = in_bytes;
    assign req_in.format = format;

    decode_pipe_stage #(
        .payload_t (operand_pkg::format_req_t)
    ) format_stage_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (req_in),
        .out_valid (req_valid),
        .out_ready (req_ready),
        .out_data  (req_q)
    );

    operand_field_select operand_field_select_inst (
        .bytes  (req_q.bytes),
        .format (req_q.format),
        .fields (fields)
    );

    decode_pipe_stage #(
        .payload_t (operand_pkg::operand_fields_t)
    ) fields_stage_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (fields),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_fields)
    );

    // An accepted item reaches the output two cycles later when not stalled.
    assert property (@(posedge clk) disable iff (reset)
        (in_valid && in_ready) ##1 out_ready |=> out_valid)
        else $error("operand decoder missed its two-cycle latency");

endmodule

// File: sim/operand_ref_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand field reference model.
// Computes the expected operand fields of an instruction
// straight from its opcode groups.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef OPERAND_REF_MODEL_SVH
`define OPERAND_REF_MODEL_SVH

function automatic operand_pkg::operand_fields_t expected_fields(
    input operand_pkg::instr_bytes_t instr
);
    logic [7:0] op;
    logic [7:0] b1;
    logic [7:0] b2;
    operand_pkg::operand_fields_t f;

    op = instr[0];
    b1 = instr[1];
    b2 = instr[2];
    f  = '0;

    if (op == 8'h0F) begin
        if (b1 inside {8'hB6, 8'hB7, 8'hBE, 8'hBF}) begin
            f.w   = b1[0];
            f.gpr = b2[5:3];
            f.mod = b2[7:6];
            f.rm  = b2[2:0];
        end else if (b1 == 8'hBC || b1 == 8'hBD) begin
            f.gpr = b2[5:3];
            f.mod = b2[7:6];
            f.rm  = b2[2:0];
        end else if (b1 >= 8'h90 && b1 <= 8'h9F) begin
            f.mod = b2[7:6];
            f.rm  = b2[2:0];
        end else if (b1 inside {8'hA0, 8'hA1, 8'hA8, 8'hA9}) begin
            f.sreg3 = b1[5:3];
        end
    end else if (op >= 8'h88 && op <= 8'h8B) begin
        f.w   = op[0];
        f.gpr = b1[5:3];
        f.mod = b1[7:6];
        f.rm  = b1[2:0];
    end else if (op < 8'h40 && op[2:0] <= 3'd3) begin // Eight ALU rows, four r/m forms each.
        f.w   = op[0];
        f.mod = b1[7:6];
        f.rm  = b1[2:0];
    end else if (op inside {8'h80, 8'h81, 8'h83}) begin
        f.s   = op[1];
        f.w   = op[0];
        f.mod = b1[7:6];
        f.rm  = b1[2:0];
    end else if ((op >= 8'h40 && op <= 8'h5F) || (op >= 8'h90 && op <= 8'h97)) begin
        f.gpr = op[2:0];
    end else if (op >= 8'hB0 && op <= 8'hBF) begin
        f.w   = op[3];
        f.gpr = op[2:0];
    end else if (op == 8'h8C || op == 8'h8E) begin
        f.sreg3 = b1[5:3];
        f.mod   = b1[7:6];
        f.rm    = b1[2:0];
    end else if (op inside {8'h06, 8'h07, 8'h0E, 8'h16, 8'h17, 8'h1E, 8'h1F}) begin
        f.sreg2 = op[4:3];
    end
    return f;
endfunction

`endif

// File: sim/operand_decoder_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand decoder testbench.
// Random instruction bytes under random back-pressure, checked
// against a reference model through a scoreboard queue.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module operand_decoder_tb;

    localparam int NUM_TXNS    = 2000;
    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int WATCHDOG_NS = NUM_TXNS * 4 * CLK_PERIOD + 10_000;

    logic                         clk;
    logic                         reset;
    logic                         in_valid;
    logic                         in_ready;
    operand_pkg::instr_bytes_t    in_bytes;
    logic                         out_valid;
    logic                         out_ready;
    operand_pkg::operand_fields_t out_fields;

    operand_pkg::operand_fields_t expected_q[$];
    operand_pkg::instr_bytes_t    bytes_q[$];
    int                           stamp_q[$];
    operand_pkg::operand_fields_t expected;
    operand_pkg::instr_bytes_t    expected_bytes;
    operand_pkg::operand_fields_t stalled_fields;
    logic                         stalled = 1'b0;
    logic                         reset_q = 1'b1;
    int                           cycle_count = 0;
    int                           accepted_count = 0;
    int                           received_count = 0;
    int                           latency;

    `include "operand_ref_model.svh"

    operand_decoder operand_decoder_inst (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_bytes   (in_bytes),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_fields (out_fields)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1);
    endtask

    // Byte 0 leans toward the kept groups and the 0F escape.
    function automatic operand_pkg::instr_bytes_t random_instruction();
        operand_pkg::instr_bytes_t instr;
        instr[0] = 8'($urandom_range(0, 255));
        instr[1] = 8'($urandom_range(0, 255));
        instr[2] = 8'($urandom_range(0, 255));
        case ($urandom_range(0, 9))
            0: instr[0] = 8'($urandom_range(0, 7) * 8 + $urandom_range(0, 3));
            1: instr[0] = {6'b100000, 2'($urandom_range(0, 3))}; // 82 stays undecoded.
            2: instr[0] = {5'b10001, 3'($urandom_range(0, 7))};
            3: instr[0] = ($urandom_range(0, 1) != 0) ? 8'h8C : 8'h8E;
            4: instr[0] = ($urandom_range(0, 1) != 0) ? 8'(8'h40 + $urandom_range(0, 31))
                                                      : 8'(8'h90 + $urandom_range(0, 7));
            5: instr[0] = {4'hB, 4'($urandom_range(0, 15))};
            6: instr[0] = {3'b000, 2'($urandom_range(0, 3)), 2'b11, 1'($urandom_range(0, 1))};
            7, 8: begin
                instr[0] = 8'h0F;
                case ($urandom_range(0, 4))
                    0: instr[1] = {4'hB, 1'($urandom_range(0, 1)), 2'b11,
                                   1'($urandom_range(0, 1))};
                    1: instr[1] = {7'b1011_110, 1'($urandom_range(0, 1))};
                    2: instr[1] = {4'h9, 4'($urandom_range(0, 15))};
                    3: instr[1] = {4'hA, 1'($urandom_range(0, 1)), 2'b00,
                                   1'($urandom_range(0, 1))};
                    default: ;
                endcase
            end
            default: ;
        endcase
        return instr;
    endfunction

    // Mostly random, with long stretches of a ready consumer.
    task automatic drive_out_ready();
        int stretch;
        stretch = 0;
        forever begin
            if (stretch > 0) begin
                out_ready = 1'b1;
                stretch   = stretch - 1;
            end else if ($urandom_range(0, 15) == 0) begin
                out_ready = 1'b1;
                stretch   = $urandom_range(10, 40);
            end else begin
                out_ready = 1'($urandom_range(0, 1));
            end
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    // Scoreboard and cycle-level checks, sampled before the edge updates land.
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (reset_q && !reset) begin
            assert (!out_valid && in_ready)
                else stop_on_error($sformatf("** Error: out_valid = %h, in_ready = %h after reset",
                                             out_valid, in_ready));
        end
        if (!reset && stalled) begin
            assert (out_valid && out_fields == stalled_fields)
                else stop_on_error($sformatf("** Error: out_fields = %h while stalled, held %h",
                                             out_fields, stalled_fields));
        end
        if (!reset && in_valid && in_ready) begin
            expected_q.push_back(expected_fields(in_bytes));
            bytes_q.push_back(in_bytes);
            stamp_q.push_back(cycle_count);
            accepted_count = accepted_count + 1;
        end
        if (!reset && out_valid && out_ready) begin
            if (expected_q.size() == 0) begin
                stop_on_error("An output transfer arrived with no input waiting for it.");
            end else begin
                expected       = expected_q.pop_front();
                expected_bytes = bytes_q.pop_front();
                latency        = cycle_count - stamp_q.pop_front();
                assert (latency >= 2)
                    else stop_on_error("An item left the decoder in fewer than two cycles.");
                assert (out_fields == expected)
                    else stop_on_error($sformatf("** Error: out_fields = %h, expected %h, bytes %h",
                                                 out_fields, expected, expected_bytes));
                received_count = received_count + 1;
            end
        end
        stalled        = !reset && out_valid && !out_ready;
        stalled_fields = out_fields;
        reset_q        = reset;
    end

    // With a ready consumer the result shows up two edges after the input transfer.
    assert property (@(posedge clk) disable iff (reset)
        (in_valid && in_ready) ##1 out_ready |=> out_valid)
        else stop_on_error("out_valid did not rise two cycles after an input transfer.");

    initial begin
        int issued;
        void'($urandom(35));
        clk       = 1'b0;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_bytes  = '0;
        out_ready = 1'b0;
        issued    = 0;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        fork
            drive_out_ready();
        join_none
        while (accepted_count < NUM_TXNS) begin
            if (!(in_valid && accepted_count < issued)) begin // Hold until taken.
                if (issued < NUM_TXNS && $urandom_range(0, 3) != 0) begin
                    in_bytes = random_instruction();
                    in_valid = 1'b1;
                    issued   = issued + 1;
                end else begin
                    in_valid = 1'b0;
                end
            end
            @(posedge clk);
            #DRIVE_DELAY;
        end
        in_valid = 1'b0;
        wait (received_count == NUM_TXNS);
        repeat (4) @(posedge clk);
        if (expected_q.size() == 0 && received_count == NUM_TXNS) begin
            $display("Verification passed");
            $finish;
        end else begin
            stop_on_error("Inputs and outputs did not balance at the end of the run.");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_on_error("Watchdog expired before all transfers completed.");
    end

endmodule

// File: files.f
+incdir+sim
design/operand_pkg.sv
design/operand_format_decoder.sv
design/operand_field_select.sv
design/decode_pipe_stage.sv
design/operand_decoder.sv
sim/operand_decoder_tb.sv

// File: Bender.yml
package:
  name: operand_decoder

sources:
  - files:
      - design/operand_pkg.sv
      - design/operand_format_decoder.sv
      - design/operand_field_select.sv
      - design/decode_pipe_stage.sv
      - design/operand_decoder.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/operand_decoder_tb.sv
